//--- opn_checker.sv
`timescale 1ns/1ns

module opn_checker
    import opn_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       clk_en,
    input  logic       busy,
    input  logic       pcm_wr,
    input  timer_cfg_t timer,
    input  test_cfg_t  test,
    input  lfo_cfg_t   lfo,
    input  dac_t       dac,
    input  logic       exp_clk_en,
    input  logic       exp_busy,
    input  logic       exp_pcm_wr,
    input  timer_cfg_t exp_timer,
    input  test_cfg_t  exp_test,
    input  lfo_cfg_t   exp_lfo,
    input  dac_t       exp_dac,
    output int         checks,
    output int         errors
);

    int check_cnt = 0;
    int error_cnt = 0;

    assign checks = check_cnt;
    assign errors = error_cnt;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Both sides sampled before this edge updates them
    always @(posedge clk) begin
        if (!rst) begin
            compare_field("clk_en", {31'd0, clk_en}, {31'd0, exp_clk_en});
            compare_field("busy", {31'd0, busy}, {31'd0, exp_busy});
            compare_field("pcm_wr", {31'd0, pcm_wr}, {31'd0, exp_pcm_wr});
            compare_field("timer", {6'd0, timer}, {6'd0, exp_timer});
            compare_field("test", {29'd0, test}, {29'd0, exp_test});
            compare_field("lfo", {28'd0, lfo}, {28'd0, exp_lfo});
            compare_field("dac", {22'd0, dac}, {22'd0, exp_dac});
        end
    end

endmodule

//--- opn_dac_regs.sv
`timescale 1ns/1ns

module opn_dac_regs
    import opn_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    clk_en,
    input  logic    wr_stb,
    input  reg_wr_t wr,
    output dac_t    dac,
    output logic    pcm_wr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            dac    <= '0;
            pcm_wr <= 1'b0;
        end else if (wr_stb) begin
            case (wr.sel)
                REG_PCM: begin
                    // Signed byte to offset binary with LSB forced high
                    dac.sample <= {~wr.data[7], wr.data[6:0], 1'b1};
                    pcm_wr     <= 1'b1;
                end
                REG_DACTEST: dac.sample[0] <= wr.data[3];
                REG_PCM_EN:  dac.en        <= wr.data[7];
                default: ;
            endcase
        end else if (clk_en) begin
            pcm_wr <= 1'b0;
        end
    end

    // Pulse ends at the first quiet clk_en
    a_pcm_wr_clear: assert property (@(posedge clk) disable iff (rst)
        (pcm_wr && clk_en && !wr_stb) |=> !pcm_wr);

endmodule

//--- opn_mmr.sv
`timescale 1ns/1ns

module opn_mmr
    import opn_pkg::*;
#(
    parameter int BUSY_TICKS = 32
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       write,
    input  logic [1:0] addr,
    input  logic [7:0] din,
    output logic       clk_en,
    output logic       busy,
    output timer_cfg_t timer,
    output test_cfg_t  test,
    output lfo_cfg_t   lfo,
    output dac_t       dac,
    output logic       pcm_wr
);

    logic     wr_stb;
    logic     data_edge;
    reg_wr_t  wr;
    div_sel_t div_sel;

    opn_write_fsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .write     (write),
        .addr      (addr),
        .din       (din),
        .wr_stb    (wr_stb),
        .wr        (wr),
        .data_edge (data_edge)
    );

    opn_timing #(
        .BUSY_TICKS (BUSY_TICKS)
    ) u_timing (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .div_sel   (div_sel),
        .data_edge (data_edge),
        .clk_en    (clk_en),
        .busy      (busy)
    );

    opn_timer_regs u_timer_regs (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .wr_stb  (wr_stb),
        .wr      (wr),
        .timer   (timer),
        .test    (test),
        .lfo     (lfo),
        .div_sel (div_sel)
    );

    opn_dac_regs u_dac_regs (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .wr_stb (wr_stb),
        .wr     (wr),
        .dac    (dac),
        .pcm_wr (pcm_wr)
    );

endmodule

//--- opn_pkg.sv
package opn_pkg;

    // Register map decoded the same in both parts
    localparam logic [7:0] REG_TESTYM  = 8'h21;
    localparam logic [7:0] REG_LFO     = 8'h22;
    localparam logic [7:0] REG_CLKA1   = 8'h24;
    localparam logic [7:0] REG_CLKA2   = 8'h25;
    localparam logic [7:0] REG_CLKB    = 8'h26;
    localparam logic [7:0] REG_TIMER   = 8'h27;
    localparam logic [7:0] REG_PCM     = 8'h2A;
    localparam logic [7:0] REG_PCM_EN  = 8'h2B;
    localparam logic [7:0] REG_DACTEST = 8'h2C;
    localparam logic [7:0] REG_CLK_N6  = 8'h2D;
    localparam logic [7:0] REG_CLK_N3  = 8'h2E;
    localparam logic [7:0] REG_CLK_N2  = 8'h2F;

    typedef logic [1:0] div_sel_t;

    localparam div_sel_t DIV_SEL_RST = 2'b11; // Divide by 6 out of reset

    // Prescaler ratio indexed by div_sel with entry 0 in the low bits
    localparam logic [3:0][2:0] DIV_RATIO = {3'd6, 3'd3, 3'd3, 3'd2};

    typedef struct packed {
        logic       part;
        logic [7:0] sel;
        logic [7:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       clr_a;    // Once-only
        logic       clr_b;    // Once-only
        logic       csm;
        logic       effect;   // CH3 special mode
    } timer_cfg_t;

    typedef struct packed {
        logic eg_stop;
        logic pg_stop;
        logic fast_timers;
    } test_cfg_t;

    typedef struct packed {
        logic       en;
        logic [2:0] freq;
    } lfo_cfg_t;

    typedef struct packed {
        logic [8:0] sample;
        logic       en;
    } dac_t;

endpackage

//--- opn_timer_regs.sv
`timescale 1ns/1ns

module opn_timer_regs
    import opn_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       clk_en,
    input  logic       wr_stb,
    input  reg_wr_t    wr,
    output timer_cfg_t timer,
    output test_cfg_t  test,
    output lfo_cfg_t   lfo,
    output div_sel_t   div_sel
);

    always_ff @(posedge clk) begin
        if (rst) begin
            timer   <= '0;
            test    <= '0;
            lfo     <= '0;
            div_sel <= DIV_SEL_RST;
        end else if (wr_stb) begin
            case (wr.sel)
                REG_TESTYM: begin
                    test.eg_stop     <= wr.data[5];
                    test.pg_stop     <= wr.data[3];
                    test.fast_timers <= wr.data[2];
                end
                REG_LFO: begin
                    lfo.en   <= wr.data[3];
                    lfo.freq <= wr.data[2:0];
                end
                REG_CLKA1: timer.value_a[9:2] <= wr.data;       // High byte
                REG_CLKA2: timer.value_a[1:0] <= wr.data[1:0];  // Low two bits
                REG_CLKB:  timer.value_b      <= wr.data;
                REG_TIMER: begin
                    // Mode field in bits 7:6
                    timer.effect   <= |wr.data[7:6];
                    timer.csm      <= wr.data[7:6] == 2'b10;
                    timer.clr_b    <= wr.data[5];
                    timer.clr_a    <= wr.data[4];
                    timer.irq_en_b <= wr.data[3];
                    timer.irq_en_a <= wr.data[2];
                    timer.load_b   <= wr.data[1];
                    timer.load_a   <= wr.data[0];
                end
                // Prescaler setting
                REG_CLK_N6: div_sel[1] <= 1'b1;
                REG_CLK_N3: div_sel[0] <= 1'b1;
                REG_CLK_N2: div_sel    <= 2'b00;
                default: ;
            endcase
        end else if (clk_en) begin
            timer.clr_a <= 1'b0;   // Flag clears last one tick
            timer.clr_b <= 1'b0;
        end
    end

endmodule

//--- opn_timing.sv
`timescale 1ns/1ns

module opn_timing
    import opn_pkg::*;
#(
    parameter int BUSY_TICKS = 32
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    input  div_sel_t div_sel,
    input  logic     data_edge,
    output logic     clk_en,
    output logic     busy
);

    localparam int BW = $clog2(BUSY_TICKS + 1);

    logic [2:0]    pre_cnt;
    logic [2:0]    ratio;
    logic          pre_wrap;
    logic [BW-1:0] busy_cnt;

    assign ratio    = DIV_RATIO[div_sel];
    assign pre_wrap = pre_cnt >= ratio - 3'd1; // Catch up at once when the ratio shrinks
    assign clk_en   = cen & pre_wrap;

    // Prescaler advances on cen only
    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt <= 3'd0;
        end else if (cen) begin
            if (pre_wrap) begin
                pre_cnt <= 3'd0;
            end else begin
                pre_cnt <= pre_cnt + 3'd1;
            end
        end
    end

    // Busy window measured in clk_en ticks
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_edge) begin
            busy     <= 1'b1;   // Restart on every data write
            busy_cnt <= '0;
        end else if (busy && clk_en) begin
            if (busy_cnt == BW'(BUSY_TICKS - 1)) begin
                busy <= 1'b0;
            end
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

    a_clk_en_single: assert property (@(posedge clk) disable iff (rst)
        clk_en |=> !clk_en);

endmodule

//--- opn_write_fsm.sv
`timescale 1ns/1ns

module opn_write_fsm
    import opn_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       write,
    input  logic [1:0] addr,
    input  logic [7:0] din,
    output logic       wr_stb,
    output reg_wr_t    wr,
    output logic       data_edge
);

    typedef enum logic {
        ADDR_PHASE,
        DATA_READY
    } state_t;

    state_t     state;
    logic       write_q;  // Previous write level
    logic [7:0] sel_q;
    logic       part_q;
    logic       addr_wr;
    logic       data_wr;

    assign addr_wr   = write & ~addr[0];
    assign data_wr   = write & addr[0];
    assign data_edge = data_wr & ~write_q; // First cycle of a data write

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ADDR_PHASE;
            write_q <= 1'b0;
            wr_stb  <= 1'b0;
        end else begin
            write_q <= write;
            wr_stb  <= data_wr;
            if (addr_wr) begin
                state <= DATA_READY;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_wr) begin
            sel_q  <= din;
            part_q <= addr[1];
        end
        if (data_wr) begin
            wr.data <= din;
            if (state == DATA_READY) begin
                wr.sel  <= sel_q;
                wr.part <= part_q;
            end else begin
                wr.sel  <= 8'h00; // No address yet so nothing decodes
                wr.part <= 1'b0;
            end
        end
    end

    // Strobe only follows a bus write
    a_stb_after_write: assert property (@(posedge clk) disable iff (rst)
        wr_stb |-> $past(write));

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_opn_mmr
./obj_dir/Vtb_opn_mmr | tee sim.log

if grep -qx "All tests passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- src.f
opn_pkg.sv
opn_write_fsm.sv
opn_timing.sv
opn_timer_regs.sv
opn_dac_regs.sv
opn_mmr.sv
opn_checker.sv
tb_opn_mmr.sv

//--- tb_opn_mmr.sv
`timescale 1ns/1ns

module tb_opn_mmr
    import opn_pkg::*;
#(
    parameter int BUSY_TICKS = 32
) ();

    localparam int NUM_OPS    = 300;
    localparam int WAIT_LIMIT = BUSY_TICKS * 120; // Generous for slow cen

    logic       clk = 1'b0;
    logic       rst;
    logic       cen;
    logic       write;
    logic [1:0] addr;
    logic [7:0] din;
    logic       clk_en;
    logic       busy;
    logic       pcm_wr;
    timer_cfg_t timer;
    test_cfg_t  test;
    lfo_cfg_t   lfo;
    dac_t       dac;

    // Reference model state
    logic       exp_clk_en;
    logic       exp_busy;
    logic       exp_pcm_wr;
    timer_cfg_t exp_timer;
    test_cfg_t  exp_test;
    lfo_cfg_t   exp_lfo;
    dac_t       exp_dac;
    logic       m_write_q;
    logic       m_have_addr;
    logic       m_stb;
    logic [7:0] m_sel;
    logic [7:0] m_wr_sel;
    logic [7:0] m_wr_data;
    logic [2:0] m_cen_cnt;   // cen-high clocks since last tick
    div_sel_t   m_div;
    int         m_busy_cnt;

    logic [31:0] seed;
    logic        cen_full;
    logic        timed_out;
    logic [7:0]  kept_regs [12];
    int          checks;
    int          errors;

    always #50 clk = ~clk;

    opn_mmr #(.BUSY_TICKS(BUSY_TICKS)) dut0 (.*);

    opn_checker chk0 (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [2:0] ratio_of(input div_sel_t d);
        case (d)
            2'd3:    return 3'd6;
            2'd0:    return 3'd2;
            default: return 3'd3;
        endcase
    endfunction

    assign exp_clk_en = cen && (m_cen_cnt + 3'd1 >= ratio_of(m_div));

    always @(posedge clk) begin
        if (rst) begin
            m_write_q   <= 1'b0;
            m_have_addr <= 1'b0;
            m_stb       <= 1'b0;
            m_cen_cnt   <= 3'd0;
            m_div       <= 2'b11;
            m_busy_cnt  <= 0;
            exp_busy    <= 1'b0;
            exp_pcm_wr  <= 1'b0;
            exp_timer   <= '0;
            exp_test    <= '0;
            exp_lfo     <= '0;
            exp_dac     <= '0;
        end else begin
            m_write_q <= write;
            m_stb     <= write & addr[0];
            if (write && !addr[0]) begin
                m_have_addr <= 1'b1;
                m_sel       <= din;
            end
            if (write && addr[0]) begin
                m_wr_sel  <= m_have_addr ? m_sel : 8'h00;
                m_wr_data <= din;
            end
            if (cen) begin
                m_cen_cnt <= exp_clk_en ? 3'd0 : m_cen_cnt + 3'd1;
            end
            if (write && addr[0] && !m_write_q) begin
                exp_busy   <= 1'b1;   // Count restarts
                m_busy_cnt <= 0;
            end else if (exp_busy && exp_clk_en) begin
                m_busy_cnt <= m_busy_cnt + 1;
                if (m_busy_cnt == BUSY_TICKS - 1) begin
                    exp_busy <= 1'b0;
                end
            end
            if (m_stb) begin
                case (m_wr_sel)
                    REG_TESTYM: exp_test <= {m_wr_data[5], m_wr_data[3], m_wr_data[2]};
                    REG_LFO:    exp_lfo  <= m_wr_data[3:0];
                    REG_CLKA1:  exp_timer.value_a[9:2] <= m_wr_data;
                    REG_CLKA2:  exp_timer.value_a[1:0] <= m_wr_data[1:0];
                    REG_CLKB:   exp_timer.value_b      <= m_wr_data;
                    REG_TIMER: begin
                        exp_timer.effect <= m_wr_data[7:6] != 2'b00;
                        exp_timer.csm    <= m_wr_data[7:6] == 2'b10;
                        {exp_timer.clr_b, exp_timer.clr_a, exp_timer.irq_en_b,
                         exp_timer.irq_en_a, exp_timer.load_b, exp_timer.load_a}
                            <= m_wr_data[5:0];
                    end
                    REG_PCM: begin
                        exp_dac.sample <= {~m_wr_data[7], m_wr_data[6:0], 1'b1};
                        exp_pcm_wr     <= 1'b1;
                    end
                    REG_DACTEST: exp_dac.sample[0] <= m_wr_data[3];
                    REG_PCM_EN:  exp_dac.en        <= m_wr_data[7];
                    REG_CLK_N6:  m_div[1] <= 1'b1;
                    REG_CLK_N3:  m_div[0] <= 1'b1;
                    REG_CLK_N2:  m_div    <= 2'b00;
                    default: ;
                endcase
            end else if (exp_clk_en) begin
                exp_timer.clr_a <= 1'b0;   // Once-only bits drop on a quiet tick
                exp_timer.clr_b <= 1'b0;
                exp_pcm_wr      <= 1'b0;
            end
        end
    end

    // One clock, new cen on the falling edge
    task automatic step();
        @(negedge clk);
        seed = lcg_step(seed);
        cen  = cen_full || seed[25:24] != 2'b00;
    endtask

    task automatic bus_write(input logic is_data, input logic part, input logic [7:0] value);
        step();
        write = 1'b1;
        addr  = {part, is_data};
        din   = value;
        step();
        write = 1'b0;
    endtask

    task automatic wait_busy_low();
        int n = 0;
        while (busy && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (busy) begin
            $display("Timeout: busy still high after %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic apply_reset();
        step();
        rst = 1'b1;
        repeat (2) step();
        rst = 1'b0;
    endtask

    initial begin
        logic [3:0] idx;
        logic [7:0] sel;
        logic [7:0] data;
        logic       part;
        logic       addr_only;
        int         gap;
        rst       = 1'b1;
        cen       = 1'b0;
        write     = 1'b0;
        addr      = 2'b00;
        din       = 8'h00;
        cen_full  = 1'b1;
        timed_out = 1'b0;
        seed      = 32'heb32_6519;
        kept_regs = '{REG_TESTYM, REG_LFO, REG_CLKA1, REG_CLKA2, REG_CLKB, REG_TIMER,
                      REG_PCM, REG_PCM_EN, REG_DACTEST, REG_CLK_N6, REG_CLK_N3, REG_CLK_N2};
        repeat (2) @(negedge clk);
        rst = 1'b0;
        bus_write(1'b1, 1'b0, 8'hA5);   // No address latched yet
        for (int op = 0; op < NUM_OPS && !timed_out; op++) begin
            if (op == NUM_OPS / 2) begin
                apply_reset();
            end
            seed      = lcg_step(seed);
            idx       = seed[31:28];
            sel       = idx < 4'd12 ? kept_regs[idx] : seed[7:0];
            data      = seed[15:8];
            part      = seed[16];
            addr_only = seed[19:17] == 3'b000;
            cen_full  = seed[27:26] == 2'b00;
            bus_write(1'b0, part, sel);
            if (!addr_only) begin
                bus_write(1'b1, part, data);
            end
            seed = lcg_step(seed);
            gap  = int'(seed[22:16]) % 81;
            repeat (gap) step();
            if (seed[31:29] == 3'b000) begin
                wait_busy_low();
            end
        end
        repeat (4) step();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
